/* dv/memSubsystemTb.sv */
`timescale 1ns/10ps

module memSubsystemTb;
    localparam int TimeoutCycles = 200;

    logic                clk;
    logic                rst;
    logic                rdy;
    logic                ioBufferFull;
    memBusPkg::fetchReqT fetchReq;
    memBusPkg::dataReqT  dataReq;
    memBusPkg::memRespT  fetchResp;
    memBusPkg::memRespT  dataResp;
    logic                fetchBusy;
    logic                dataBusy;

    // shadow copy of the 1 KB RAM
    logic [7:0] shadow [1024];
    integer     seed;
    int         errors;
    int         checks;
    bit         stallMode;

    memSubsystem #(
        .AddrWidth(10)
    ) dut0 (
        .clk           (clk),
        .rst           (rst),
        .i_rdy         (rdy),
        .i_ioBufferFull(ioBufferFull),
        .i_fetchReq    (fetchReq),
        .i_dataReq     (dataReq),
        .o_fetchResp   (fetchResp),
        .o_dataResp    (dataResp),
        .o_fetchBusy   (fetchBusy),
        .o_dataBusy    (dataBusy)
    );

    initial clk = 1'b0;
    always #10 clk = ~clk;

    task automatic compareValue(input string name, input logic [31:0] exp,
                                input logic [31:0] act);
        checks++;
        assert (act === exp) else begin
            $display("MISMATCH time %0t %s expected %h actual %h", $time, name, exp, act);
            errors++;
        end
    endtask

    task automatic expectQuiet();
        compareValue("o_fetchResp.done", 32'd0, 32'(fetchResp.done));
        compareValue("o_dataResp.done", 32'd0, 32'(dataResp.done));
        compareValue("o_fetchBusy", 32'd0, 32'(fetchBusy));
        compareValue("o_dataBusy", 32'd0, 32'(dataBusy));
    endtask

    task automatic randomizeStalls();
        if (stallMode) begin
            ioBufferFull <= ($random(seed) & 7) == 0;
            rdy          <= ($random(seed) & 7) != 0;
        end else begin
            ioBufferFull <= 1'b0;
            rdy          <= 1'b1;
        end
    endtask

    function automatic int sizeBytes(input memParamsPkg::memSizeE size);
        case (size)
            memParamsPkg::SIZE_BYTE: return 1;
            memParamsPkg::SIZE_HALF: return 2;
            default:                 return 4;
        endcase
    endfunction

    // little-endian word with zeros above nBytes, wrapping inside 1 KB
    function automatic logic [31:0] modelRead(input logic [31:0] addr, input int nBytes);
        logic [31:0] word;
        word = '0;
        for (int i = 0; i < nBytes; i++) begin
            word[8*i +: 8] = shadow[addr[9:0] + 10'(i)];
        end
        return word;
    endfunction

    function automatic void modelWrite(input logic [31:0] addr, input int nBytes,
                                       input logic [31:0] data);
        for (int i = 0; i < nBytes; i++) begin
            shadow[addr[9:0] + 10'(i)] = data[8*i +: 8];
        end
    endfunction

    // cycles counts from the first cycle the request is visible
    task automatic waitForDone(input bit forFetch, output int cycles, output bit stalled,
                               output bit gotDone, output logic [31:0] word);
        bit stall;
        bit ownDone;
        bit accepted;
        cycles   = 0;
        stalled  = 1'b0;
        gotDone  = 1'b0;
        accepted = 1'b0;
        word     = '0;
        while (!gotDone && cycles < TimeoutCycles) begin
            @(negedge clk);
            stall   = ioBufferFull || !rdy;
            stalled = stalled || stall;
            checks++;
            assert (!(stall && (fetchResp.done || dataResp.done))) else begin
                $display("done pulsed at %0t while a stall was active", $time);
                errors++;
            end
            // data always goes first so the other client stays idle
            // own busy rises on the edge that accepts the request
            if (forFetch) begin
                compareValue("o_dataResp.done", 32'd0, 32'(dataResp.done));
                compareValue("o_dataBusy", 32'd0, 32'(dataBusy));
                compareValue("o_fetchBusy", 32'(accepted), 32'(fetchBusy));
                ownDone = fetchResp.done;
            end else begin
                compareValue("o_fetchResp.done", 32'd0, 32'(fetchResp.done));
                compareValue("o_fetchBusy", 32'd0, 32'(fetchBusy));
                compareValue("o_dataBusy", 32'(accepted), 32'(dataBusy));
                ownDone = dataResp.done;
            end
            accepted = accepted || !stall;
            if (ownDone) begin
                gotDone = 1'b1;
                word    = forFetch ? fetchResp.rdata : dataResp.rdata;
            end else begin
                cycles++;
                @(posedge clk);
                randomizeStalls();
            end
        end
        checks++;
        assert (gotDone) else begin
            $display("timeout at %0t, no done within %0d cycles", $time, TimeoutCycles);
            errors++;
        end
    endtask

    task automatic transfer(input bit doFetch, input bit doData,
                            input memParamsPkg::memOpE op, input memParamsPkg::memSizeE size,
                            input logic [31:0] dataAddr, input logic [31:0] wdata,
                            input logic [31:0] fetchAddr);
        int          cycles;
        int          nBytes;
        bit          stalled;
        bit          gotDone;
        logic [31:0] word;
        nBytes = sizeBytes(size);
        @(posedge clk);
        fetchReq.valid <= doFetch;
        fetchReq.addr  <= fetchAddr;
        dataReq.valid  <= doData;
        dataReq.op     <= op;
        dataReq.size   <= size;
        dataReq.addr   <= dataAddr;
        dataReq.wdata  <= wdata;
        randomizeStalls();
        if (doData) begin
            waitForDone(1'b0, cycles, stalled, gotDone, word);
            @(posedge clk);
            dataReq.valid <= 1'b0;
            randomizeStalls();
            if (gotDone && op == memParamsPkg::OP_STORE) begin
                modelWrite(dataAddr, nBytes, wdata);
                if (!stalled) compareValue("store done latency", 32'(nBytes), 32'(cycles));
            end else if (gotDone) begin
                compareValue("o_dataResp.rdata", modelRead(dataAddr, nBytes), word);
                if (!stalled) compareValue("load done latency", 32'(nBytes + 1), 32'(cycles));
            end
        end
        if (doFetch) begin
            waitForDone(1'b1, cycles, stalled, gotDone, word);
            @(posedge clk);
            fetchReq.valid <= 1'b0;
            if (gotDone) begin
                compareValue("o_fetchResp.rdata", modelRead(fetchAddr, 4), word);
                if (!stalled) compareValue("fetch done latency", 32'd5, 32'(cycles));
            end
        end
        ioBufferFull <= 1'b0;
        rdy          <= 1'b1;
        @(negedge clk);
        expectQuiet();
    endtask

    initial begin
        memParamsPkg::memSizeE size;
        memParamsPkg::memOpE   op;
        logic [31:0]           addr;
        logic [31:0]           r;
        seed         = 32'haf19_f61b;
        errors       = 0;
        checks       = 0;
        stallMode    = 1'b0;
        rst          = 1'b1;
        rdy          = 1'b1;
        ioBufferFull = 1'b0;
        fetchReq     = '0;
        dataReq      = '0;
        repeat (8) @(posedge clk);
        rst <= 1'b0;
        @(negedge clk);
        expectQuiet();
        // give every byte a known value
        for (int a = 0; a < 1024; a += 4) begin
            transfer(1'b0, 1'b1, memParamsPkg::OP_STORE, memParamsPkg::SIZE_WORD, 32'(a),
                     $random(seed), 32'd0);
        end
        for (int t = 0; t < 300; t++) begin
            stallMode = (t / 50) % 2 == 1;
            r         = $random(seed);
            addr      = $random(seed);
            size      = (r[3:2] == 2'd0) ? memParamsPkg::SIZE_BYTE :
                        (r[3:2] == 2'd1) ? memParamsPkg::SIZE_HALF : memParamsPkg::SIZE_WORD;
            op        = r[4] ? memParamsPkg::OP_STORE : memParamsPkg::OP_LOAD;
            case (r[1:0])
                2'd0: transfer(1'b1, 1'b0, op, size, 32'd0, 32'd0, addr);
                2'd1: transfer(1'b0, 1'b1, memParamsPkg::OP_LOAD, size, addr, 32'd0, 32'd0);
                2'd2: begin
                    transfer(1'b0, 1'b1, memParamsPkg::OP_STORE, size, addr, $random(seed),
                             32'd0);
                    // word readback shows the bytes past the store untouched
                    transfer(1'b0, 1'b1, memParamsPkg::OP_LOAD, memParamsPkg::SIZE_WORD, addr,
                             32'd0, 32'd0);
                end
                default: transfer(1'b1, 1'b1, op, size, addr, $random(seed), $random(seed));
            endcase
        end
        $display("checks %0d errors %0d", checks, errors);
        if (errors == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

/* memSubsystem.f */
source/memParamsPkg.sv
source/memBusPkg.sv
source/byteRam.sv
source/loadAssembler.sv
source/storeSlicer.sv
source/memCtrl.sv
source/memSubsystem.sv
dv/memSubsystemTb.sv

/* run.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --assert --timescale 1ns/10ps --top-module memSubsystemTb \
    -f memSubsystem.f -Mdir obj_dir -o simv

out=$(./obj_dir/simv || true)
echo "$out"

if echo "$out" | grep -qx "All checks passed"; then
    exit 0
fi
exit 1

/* source/byteRam.sv */
`timescale 1ns/10ps

module byteRam #(
    parameter int AddrWidth = 16
) (
    input  logic               clk,
    input  memBusPkg::ramPortT i_port,
    output logic [7:0]         o_rdByte
);
    logic [7:0]           mem [2**AddrWidth];
    logic [AddrWidth-1:0] addr;

    assign addr = i_port.addr[AddrWidth-1:0];

    // read returns old data on a same-cycle write
    always_ff @(posedge clk) begin
        if (i_port.we) begin
            mem[addr] <= i_port.wdata;
        end
        o_rdByte <= mem[addr];
    end

    knownWriteAddr: assert property (@(posedge clk)
        i_port.we |-> !$isunknown(addr))
        else $error("RAM write with unknown address");

endmodule

/* source/loadAssembler.sv */
`timescale 1ns/10ps

module loadAssembler (
    input  logic                                clk,
    input  logic                                rst,
    input  logic                                i_start,
    input  logic                                i_capture,
    input  logic [memParamsPkg::StageWidth-1:0] i_index,
    input  memParamsPkg::memSizeE               i_size,
    input  logic [7:0]                          i_rdByte,
    output logic [memParamsPkg::DataWidth-1:0]  o_word
);
    localparam int Dw = memParamsPkg::DataWidth;

    memParamsPkg::memSizeE sizeQ;
    logic [Dw-1:0]         wordQ;
    logic [Dw-1:0]         merged;

    always_ff @(posedge clk) begin
        if (rst) begin
            sizeQ <= memParamsPkg::SIZE_WORD;
        end else if (i_start) begin
            sizeQ <= i_size;
        end
    end

    always_ff @(posedge clk) begin
        if (i_start) begin
            wordQ <= '0;
        end else if (i_capture) begin
            wordQ[8*i_index +: 8] <= i_rdByte;
        end
    end

    // last byte goes straight through so done can carry the full word
    always_comb begin
        merged = wordQ;
        if (i_capture) begin
            merged[8*i_index +: 8] = i_rdByte;
        end
        case (sizeQ)
            memParamsPkg::SIZE_BYTE: o_word = {{(Dw-8){1'b0}}, merged[7:0]};
            memParamsPkg::SIZE_HALF: o_word = {{(Dw-16){1'b0}}, merged[15:0]};
            default:                 o_word = merged;
        endcase
    end

endmodule

/* source/memBusPkg.sv */
package memBusPkg;

    // full bus address, modules keep only the low bits they decode
    localparam int MaxAddrWidth = 32;

    // instruction fetch, always four bytes
    typedef struct packed {
        logic                    valid;
        logic [MaxAddrWidth-1:0] addr;
    } fetchReqT;

    typedef struct packed {
        logic                               valid;
        memParamsPkg::memOpE                op;
        memParamsPkg::memSizeE              size;
        logic [MaxAddrWidth-1:0]            addr;
        logic [memParamsPkg::DataWidth-1:0] wdata;
    } dataReqT;

    // done is a one-cycle pulse
    typedef struct packed {
        logic                               done;
        logic [memParamsPkg::DataWidth-1:0] rdata;
    } memRespT;

    // one byte per cycle into the RAM
    typedef struct packed {
        logic                    we;
        logic [MaxAddrWidth-1:0] addr;
        logic [7:0]              wdata;
    } ramPortT;

endpackage

/* source/memCtrl.sv */
`timescale 1ns/10ps

module memCtrl #(
    parameter int AddrWidth = 16
) (
    input  logic                                   clk,
    input  logic                                   rst,
    input  logic                                   i_rdy,
    input  logic                                   i_ioBufferFull,
    input  memBusPkg::fetchReqT                    i_fetchReq,
    input  memBusPkg::dataReqT                     i_dataReq,
    input  logic [memParamsPkg::DataWidth-1:0]     i_asmWord,
    input  logic [7:0]                             i_storeByte,
    output memBusPkg::ramPortT                     o_ram,
    output logic                                   o_asmStart,
    output logic                                   o_asmCapture,
    output logic [memParamsPkg::StageWidth-1:0]    o_asmIndex,
    output memParamsPkg::memSizeE                  o_asmSize,
    output logic                                   o_slicerLoad,
    output logic [memParamsPkg::StageWidth-1:0]    o_slicerIndex,
    output memBusPkg::memRespT                     o_fetchResp,
    output memBusPkg::memRespT                     o_dataResp,
    output logic                                   o_fetchBusy,
    output logic                                   o_dataBusy
);
    localparam int Sw = memParamsPkg::StageWidth;

    memParamsPkg::ctrlStateE state;
    memParamsPkg::memSizeE   sizeQ;
    memParamsPkg::memSizeE   acceptSize;
    logic [Sw-1:0]           stage;
    logic [Sw-1:0]           byteCount;
    logic [Sw-1:0]           lastStage;
    logic [Sw-1:0]           addrOffset;
    logic [AddrWidth-1:0]    baseAddr;
    logic [AddrWidth-1:0]    acceptAddr;
    logic [AddrWidth-1:0]    ramAddr;
    logic                    frozen;
    logic                    accept;
    logic                    readState;
    logic                    xferDone;

    // everything holds while the output buffer is full or not ready
    assign frozen = i_ioBufferFull || !i_rdy;

    assign accept = (state == memParamsPkg::ST_IDLE) && !frozen &&
                    (i_dataReq.valid || i_fetchReq.valid);

    // data side wins when both wait
    assign acceptSize = i_dataReq.valid ? i_dataReq.size : memParamsPkg::SIZE_WORD;
    assign acceptAddr = i_dataReq.valid ? i_dataReq.addr[AddrWidth-1:0]
                                        : i_fetchReq.addr[AddrWidth-1:0];

    always_comb begin
        case (sizeQ)
            memParamsPkg::SIZE_BYTE: byteCount = Sw'(1);
            memParamsPkg::SIZE_HALF: byteCount = Sw'(2);
            default:                 byteCount = Sw'(4);
        endcase
    end

    // stores finish with the last write and reads one cycle after the last address
    assign lastStage = (state == memParamsPkg::ST_STORE) ? byteCount - Sw'(1) : byteCount;

    assign readState = (state == memParamsPkg::ST_FETCH) || (state == memParamsPkg::ST_LOAD);
    assign xferDone  = (state != memParamsPkg::ST_IDLE) && (stage == lastStage) && !frozen;

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= memParamsPkg::ST_IDLE;
            stage <= '0;
        end else if (!frozen) begin
            case (state)
                memParamsPkg::ST_IDLE: begin
                    stage <= '0;
                    if (i_dataReq.valid) begin
                        state <= (i_dataReq.op == memParamsPkg::OP_STORE) ?
                                 memParamsPkg::ST_STORE : memParamsPkg::ST_LOAD;
                    end else if (i_fetchReq.valid) begin
                        state <= memParamsPkg::ST_FETCH;
                    end
                end
                default: begin
                    if (stage == lastStage) begin
                        state <= memParamsPkg::ST_IDLE;
                        stage <= '0;
                    end else begin
                        stage <= stage + Sw'(1);
                    end
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            baseAddr <= acceptAddr;
            sizeQ    <= acceptSize;
        end
    end

    // re-read the previous byte while frozen so the returning byte stays valid
    assign addrOffset = (frozen && readState) ? stage - Sw'(1) : stage;
    assign ramAddr    = baseAddr + {{(AddrWidth-Sw){1'b0}}, addrOffset};

    always_comb begin
        o_ram                      = '0;
        o_ram.addr[AddrWidth-1:0]  = ramAddr;
        o_ram.wdata                = i_storeByte;
        o_ram.we                   = (state == memParamsPkg::ST_STORE) && !frozen;
    end

    assign o_asmStart    = accept;
    assign o_asmSize     = acceptSize;
    assign o_asmCapture  = readState && (stage != '0) && !frozen;
    assign o_asmIndex    = stage - Sw'(1);
    assign o_slicerLoad  = accept && i_dataReq.valid;
    assign o_slicerIndex = stage;

    assign o_fetchResp.done  = xferDone && (state == memParamsPkg::ST_FETCH);
    assign o_fetchResp.rdata = o_fetchResp.done ? i_asmWord : '0;
    assign o_dataResp.done   = xferDone && (state != memParamsPkg::ST_FETCH);
    assign o_dataResp.rdata  = (o_dataResp.done && state == memParamsPkg::ST_LOAD) ?
                               i_asmWord : '0;

    assign o_fetchBusy = (state == memParamsPkg::ST_FETCH);
    assign o_dataBusy  = (state == memParamsPkg::ST_LOAD) || (state == memParamsPkg::ST_STORE);

    // a finished transfer hands the FSM back to idle
    doneReturnsIdle: assert property (@(posedge clk) disable iff (rst)
        (o_fetchResp.done || o_dataResp.done) |=> (state == memParamsPkg::ST_IDLE))
        else $error("FSM not idle in the cycle after done");

    writeInsideStore: assert property (@(posedge clk) disable iff (rst)
        o_ram.we |-> (stage < byteCount))
        else $error("RAM write past the bytes of the store");

endmodule

/* source/memParamsPkg.sv */
package memParamsPkg;

    // instruction and data word width
    localparam int DataWidth = 32;

    // counts byte stages 0 to 4
    localparam int StageWidth = 3;

    typedef enum logic {
        OP_LOAD,
        OP_STORE
    } memOpE;

    // loads are zero-extended, so no signed sizes
    typedef enum logic [1:0] {
        SIZE_BYTE,
        SIZE_HALF,
        SIZE_WORD
    } memSizeE;

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_FETCH,
        ST_LOAD,
        ST_STORE
    } ctrlStateE;

endpackage

/* source/memSubsystem.sv */
`timescale 1ns/10ps

module memSubsystem #(
    parameter int AddrWidth = 16
) (
    input  logic                clk,
    input  logic                rst,
    input  logic                i_rdy,
    input  logic                i_ioBufferFull,
    input  memBusPkg::fetchReqT i_fetchReq,
    input  memBusPkg::dataReqT  i_dataReq,
    output memBusPkg::memRespT  o_fetchResp,
    output memBusPkg::memRespT  o_dataResp,
    output logic                o_fetchBusy,
    output logic                o_dataBusy
);
    memBusPkg::ramPortT                      ramPort;
    logic [7:0]                              rdByte;
    logic [7:0]                              storeByte;
    logic [memParamsPkg::DataWidth-1:0]      asmWord;
    logic                                    asmStart;
    logic                                    asmCapture;
    logic [memParamsPkg::StageWidth-1:0]     asmIndex;
    memParamsPkg::memSizeE                   asmSize;
    logic                                    slicerLoad;
    logic [memParamsPkg::StageWidth-1:0]     slicerIndex;

    memCtrl #(
        .AddrWidth(AddrWidth)
    ) ctrl0 (
        .clk           (clk),
        .rst           (rst),
        .i_rdy         (i_rdy),
        .i_ioBufferFull(i_ioBufferFull),
        .i_fetchReq    (i_fetchReq),
        .i_dataReq     (i_dataReq),
        .i_asmWord     (asmWord),
        .i_storeByte   (storeByte),
        .o_ram         (ramPort),
        .o_asmStart    (asmStart),
        .o_asmCapture  (asmCapture),
        .o_asmIndex    (asmIndex),
        .o_asmSize     (asmSize),
        .o_slicerLoad  (slicerLoad),
        .o_slicerIndex (slicerIndex),
        .o_fetchResp   (o_fetchResp),
        .o_dataResp    (o_dataResp),
        .o_fetchBusy   (o_fetchBusy),
        .o_dataBusy    (o_dataBusy)
    );

    loadAssembler asm0 (
        .clk      (clk),
        .rst      (rst),
        .i_start  (asmStart),
        .i_capture(asmCapture),
        .i_index  (asmIndex),
        .i_size   (asmSize),
        .i_rdByte (rdByte),
        .o_word   (asmWord)
    );

    storeSlicer slicer0 (
        .clk    (clk),
        .rst    (rst),
        .i_load (slicerLoad),
        .i_wdata(i_dataReq.wdata),
        .i_index(slicerIndex),
        .o_byte (storeByte)
    );

    byteRam #(
        .AddrWidth(AddrWidth)
    ) ram0 (
        .clk     (clk),
        .i_port  (ramPort),
        .o_rdByte(rdByte)
    );

endmodule

/* source/storeSlicer.sv */
`timescale 1ns/10ps

module storeSlicer (
    input  logic                                clk,
    input  logic                                rst,
    input  logic                                i_load,
    input  logic [memParamsPkg::DataWidth-1:0]  i_wdata,
    input  logic [memParamsPkg::StageWidth-1:0] i_index,
    output logic [7:0]                          o_byte
);
    logic [memParamsPkg::DataWidth-1:0] wordQ;

    // client bus value only matters at acceptance
    always_ff @(posedge clk) begin
        if (rst) begin
            wordQ <= '0;
        end else if (i_load) begin
            wordQ <= i_wdata;
        end
    end

    // little-endian, stage 0 is the lowest byte
    always_comb begin
        case (i_index)
            memParamsPkg::StageWidth'(0): o_byte = wordQ[7:0];
            memParamsPkg::StageWidth'(1): o_byte = wordQ[15:8];
            memParamsPkg::StageWidth'(2): o_byte = wordQ[23:16];
            default:                      o_byte = wordQ[31:24];
        endcase
    end

endmodule
